// File: verilog/rv32m_muldiv_pkg.sv
package rv32m_muldiv_pkg;

    // ========================================
    // Data types
    // ========================================

    // Operand and result word
    typedef logic [31:0] word_t;

    // RV32M operations in funct3 order
    // Top bit set marks the divide family
    typedef enum logic [2:0] {
        MUL    = 3'b000,
        MULH   = 3'b001,
        MULHSU = 3'b010,
        MULHU  = 3'b011,
        DIV    = 3'b100,
        DIVU   = 3'b101,
        REM    = 3'b110,
        REMU   = 3'b111
    } muldiv_op_e;

    // ========================================
    // Timing
    // ========================================

    // One load cycle plus 32 shift-subtract steps
    localparam int unsigned DIV_CYCLES = 33;

endpackage

// File: verilog/muldiv_if.sv
`timescale 1ns/1ps

interface muldiv_if;

    // Request side
    logic                         start;
    rv32m_muldiv_pkg::muldiv_op_e op;
    rv32m_muldiv_pkg::word_t      operand_a;
    rv32m_muldiv_pkg::word_t      operand_b;

    // Result side, valid while done is high
    rv32m_muldiv_pkg::word_t      result;
    logic                         done;

    // Controller drives the request
    modport ctrl (
        output start, op, operand_a, operand_b,
        input  result, done
    );

    // Arithmetic unit returns the result
    modport unit (
        input  start, op, operand_a, operand_b,
        output result, done
    );

endinterface

// File: verilog/mult_unit.sv
`timescale 1ns/1ps

module mult_unit #(
    parameter int MULT_LATENCY = 3
) (
    input  logic   clk_i,
    input  logic   rst_ni,
    muldiv_if.unit req
);

    // ========================================
    // Pipeline state
    // ========================================

    rv32m_muldiv_pkg::word_t      a_q;
    rv32m_muldiv_pkg::word_t      b_q;
    rv32m_muldiv_pkg::muldiv_op_e op_q [MULT_LATENCY];
    logic [MULT_LATENCY-1:0]      valid_q;
    logic [63:0]                  prod_d [MULT_LATENCY];

    // Sign-extended operands for the one shared multiplier
    logic                         a_signed;
    logic                         b_signed;
    logic signed [32:0]           a_ext;
    logic signed [32:0]           b_ext;
    logic signed [65:0]           prod_full;

    // Valid bit walks down the chain, one stage per cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= req.start;
            for (int i = 1; i < MULT_LATENCY; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // Stage one captures operands, op travels with its item
    always_ff @(posedge clk_i) begin
        if (req.start) begin
            a_q     <= req.operand_a;
            b_q     <= req.operand_b;
            op_q[0] <= req.op;
        end
        for (int i = 1; i < MULT_LATENCY; i++) begin
            op_q[i] <= op_q[i-1];
        end
    end

    // MULHU is unsigned on both sides, MULHSU only on b
    // Low half of MUL is the same for any signedness
    assign a_signed  = (op_q[0] != rv32m_muldiv_pkg::MULHU);
    assign b_signed  = (op_q[0] == rv32m_muldiv_pkg::MUL) || (op_q[0] == rv32m_muldiv_pkg::MULH);
    assign a_ext     = {a_signed & a_q[31], a_q};
    assign b_ext     = {b_signed & b_q[31], b_q};
    assign prod_full = a_ext * b_ext;
    assign prod_d[0] = prod_full[63:0];

    // Product registers for the remaining stages
    for (genvar g = 1; g < MULT_LATENCY; g++) begin : g_stage
        logic [63:0] prod_q;

        always_ff @(posedge clk_i) begin
            prod_q <= prod_d[g-1];
        end

        assign prod_d[g] = prod_q;
    end

    // ========================================
    // Last stage half select
    // ========================================

    assign req.result = (op_q[MULT_LATENCY-1] == rv32m_muldiv_pkg::MUL) ?
                        prod_d[MULT_LATENCY-1][31:0] : prod_d[MULT_LATENCY-1][63:32];
    assign req.done   = valid_q[MULT_LATENCY-1];

    // Controller must only steer multiplies here
    start_is_mul: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req.start |-> !req.op[2]);

    // Fixed latency from sample edge to done
    done_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req.start |-> ##MULT_LATENCY req.done);

endmodule

// File: verilog/div_unit.sv
`timescale 1ns/1ps

module div_unit (
    input  logic   clk_i,
    input  logic   rst_ni,
    muldiv_if.unit req
);

    typedef enum logic [1:0] {
        IDLE,
        CALC,
        DONE
    } state_e;

    // Count value of the final iteration
    localparam logic [4:0] LAST_STEP = 5'(rv32m_muldiv_pkg::DIV_CYCLES - 2);

    // ========================================
    // Control state
    // ========================================

    state_e                       state_q;
    logic [4:0]                   cnt_q;

    // Operation payload
    rv32m_muldiv_pkg::muldiv_op_e op_q;
    rv32m_muldiv_pkg::word_t      dividend_q;
    rv32m_muldiv_pkg::word_t      divisor_q;
    rv32m_muldiv_pkg::word_t      quot_q;
    rv32m_muldiv_pkg::word_t      rem_q;
    logic                         neg_quot_q;
    logic                         neg_rem_q;
    logic                         div_zero_q;
    logic                         overflow_q;

    // Input decode and iteration datapath
    logic                         is_signed;
    logic                         a_neg;
    logic                         b_neg;
    logic [32:0]                  rem_shift;
    logic                         rem_fits;
    rv32m_muldiv_pkg::word_t      quot_out;
    rv32m_muldiv_pkg::word_t      rem_out;

    // DIV and REM have bit 0 clear
    assign is_signed = !req.op[0];
    assign a_neg     = is_signed & req.operand_a[31];
    assign b_neg     = is_signed & req.operand_b[31];

    // Restoring step on the shifted partial remainder
    assign rem_shift = {rem_q, quot_q[31]};
    assign rem_fits  = (rem_shift >= {1'b0, divisor_q});

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req.start) begin
                        state_q <= CALC;
                        cnt_q   <= '0;
                    end
                end
                CALC: begin
                    if (cnt_q == LAST_STEP) begin
                        state_q <= DONE;
                    end
                    cnt_q <= cnt_q + 5'd1;
                end
                DONE:    state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // ========================================
    // Load and shift-subtract
    // ========================================

    always_ff @(posedge clk_i) begin
        if ((state_q == IDLE) && req.start) begin
            op_q       <= req.op;
            dividend_q <= req.operand_a;
            divisor_q  <= b_neg ? -req.operand_b : req.operand_b;
            quot_q     <= a_neg ? -req.operand_a : req.operand_a;
            rem_q      <= '0;
            neg_quot_q <= a_neg ^ b_neg;
            neg_rem_q  <= a_neg;
            div_zero_q <= (req.operand_b == '0);
            overflow_q <= is_signed && (req.operand_a == 32'h8000_0000) && (req.operand_b == '1);
        end else if (state_q == CALC) begin
            quot_q <= {quot_q[30:0], rem_fits};
            rem_q  <= rem_fits ? 32'(rem_shift - {1'b0, divisor_q}) : rem_shift[31:0];
        end
    end

    // Sign fix-up, then RISC-V special values override
    always_comb begin
        quot_out = neg_quot_q ? -quot_q : quot_q;
        rem_out  = neg_rem_q ? -rem_q : rem_q;
        if (div_zero_q) begin
            quot_out = '1;
            rem_out  = dividend_q;
        end else if (overflow_q) begin
            quot_out = dividend_q;
            rem_out  = '0;
        end
    end

    // REM and REMU have bit 1 set
    assign req.result = op_q[1] ? rem_out : quot_out;
    assign req.done   = (state_q == DONE);

    // Busy logic upstream keeps starts away from a running divide
    start_when_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req.start |-> (state_q == IDLE));

endmodule

// File: verilog/muldiv_ctrl.sv
`timescale 1ns/1ps

module muldiv_ctrl #(
    parameter int MULT_LATENCY = 3
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         start_i,
    input  rv32m_muldiv_pkg::muldiv_op_e op_i,
    input  rv32m_muldiv_pkg::word_t      operand_a_i,
    input  rv32m_muldiv_pkg::word_t      operand_b_i,
    output rv32m_muldiv_pkg::word_t      result_o,
    output logic                         done_o,
    output logic                         busy_o,
    muldiv_if.ctrl                       mul,
    muldiv_if.ctrl                       div
);

    // Wide enough to count MULT_LATENCY items
    localparam int CNT_W = $clog2(MULT_LATENCY + 1);

    logic [CNT_W-1:0] mul_cnt_q;
    logic             div_run_q;
    logic             is_div;
    logic             accept;

    // ========================================
    // Dispatch
    // ========================================

    assign is_div = op_i[2];

    // Divide waits for the multiplier to drain, keeps issue order
    assign busy_o = div_run_q | (is_div & (mul_cnt_q != '0));
    assign accept = start_i & ~busy_o;

    assign mul.start     = accept & ~is_div;
    assign mul.op        = op_i;
    assign mul.operand_a = operand_a_i;
    assign mul.operand_b = operand_b_i;

    assign div.start     = accept & is_div;
    assign div.op        = op_i;
    assign div.operand_a = operand_a_i;
    assign div.operand_b = operand_b_i;

    // Multiplies in flight and divider running flag
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mul_cnt_q <= '0;
            div_run_q <= 1'b0;
        end else begin
            mul_cnt_q <= mul_cnt_q + CNT_W'(mul.start) - CNT_W'(mul.done);
            if (div.start) begin
                div_run_q <= 1'b1;
            end else if (div.done) begin
                div_run_q <= 1'b0;
            end
        end
    end

    // ========================================
    // Result merge
    // ========================================

    always_comb begin
        done_o = mul.done | div.done;
        if (mul.done) begin
            result_o = mul.result;
        end else if (div.done) begin
            result_o = div.result;
        end else begin
            result_o = '0;
        end
    end

    // Ordering rule means the units never finish together
    one_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(mul.done && div.done));

    start_while_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        start_i |-> !busy_o) else $error("start_i while busy_o, request dropped");

endmodule

// File: verilog/rv32m_muldiv_top.sv
`timescale 1ns/1ps

module rv32m_muldiv_top #(
    parameter int MULT_LATENCY = 3
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         start_i,
    input  rv32m_muldiv_pkg::muldiv_op_e op_i,
    input  rv32m_muldiv_pkg::word_t      operand_a_i,
    input  rv32m_muldiv_pkg::word_t      operand_b_i,
    output rv32m_muldiv_pkg::word_t      result_o,
    output logic                         done_o,
    output logic                         busy_o
);

    // One request channel per arithmetic unit
    muldiv_if mul_if_i ();
    muldiv_if div_if_i ();

    // Routing, ordering and result merge
    muldiv_ctrl #(
        .MULT_LATENCY(MULT_LATENCY)
    ) muldiv_ctrl_i (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .start_i    (start_i),
        .op_i       (op_i),
        .operand_a_i(operand_a_i),
        .operand_b_i(operand_b_i),
        .result_o   (result_o),
        .done_o     (done_o),
        .busy_o     (busy_o),
        .mul        (mul_if_i.ctrl),
        .div        (div_if_i.ctrl)
    );

    // Pipelined multiplier
    mult_unit #(
        .MULT_LATENCY(MULT_LATENCY)
    ) mult_unit_i (
        .clk_i (clk_i),
        .rst_ni(rst_ni),
        .req   (mul_if_i.unit)
    );

    // Iterative divider
    div_unit div_unit_i (
        .clk_i (clk_i),
        .rst_ni(rst_ni),
        .req   (div_if_i.unit)
    );

endmodule

// File: bench/rv32m_muldiv_tb.sv
`timescale 1ns/1ps

module rv32m_muldiv_tb;

    localparam int MULT_LATENCY = 3;
    localparam int N_CORNER     = 5;
    localparam int N_B2B        = 40;
    localparam int N_SPECIAL    = 12;
    localparam int N_RANDOM     = 200;
    localparam int NUM_OPS      = 2 * 4 * N_CORNER * N_CORNER + N_B2B + N_SPECIAL + N_RANDOM;

    logic                         clk_i;
    logic                         rst_ni;
    logic                         start_i;
    rv32m_muldiv_pkg::muldiv_op_e op_i;
    rv32m_muldiv_pkg::word_t      operand_a_i;
    rv32m_muldiv_pkg::word_t      operand_b_i;
    rv32m_muldiv_pkg::word_t      result_o;
    logic                         done_o;
    logic                         busy_o;

    // Expected result, latency and issue cycle of each request in flight
    rv32m_muldiv_pkg::word_t      exp_q [$];
    int                           lat_q [$];
    int                           issue_q [$];
    int                           cycle;
    int                           checks;
    int                           errors;
    int                           err_start;
    rv32m_muldiv_pkg::word_t      corners [N_CORNER] = '{32'h0000_0000, 32'h0000_0001,
                                                         32'hffff_ffff, 32'h8000_0000,
                                                         32'h7fff_ffff};

    rv32m_muldiv_top #(
        .MULT_LATENCY(MULT_LATENCY)
    ) rv32m_muldiv_top_i (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .start_i    (start_i),
        .op_i       (op_i),
        .operand_a_i(operand_a_i),
        .operand_b_i(operand_b_i),
        .result_o   (result_o),
        .done_o     (done_o),
        .busy_o     (busy_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle <= cycle + 1;

    // ========================================
    // Reference model
    // ========================================

    // 64-bit arithmetic with the RISC-V rules for zero divisor and overflow
    function automatic rv32m_muldiv_pkg::word_t ref_result(rv32m_muldiv_pkg::muldiv_op_e op,
                                                           rv32m_muldiv_pkg::word_t a,
                                                           rv32m_muldiv_pkg::word_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] ua;
        logic signed [63:0] ub;
        logic signed [63:0] r;
        logic               ovf;
        sa  = {{32{a[31]}}, a};
        sb  = {{32{b[31]}}, b};
        ua  = {32'h0, a};
        ub  = {32'h0, b};
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (op)
            rv32m_muldiv_pkg::MUL:    r = sa * sb;
            rv32m_muldiv_pkg::MULH:   r = (sa * sb) >>> 32;
            rv32m_muldiv_pkg::MULHSU: r = (sa * ub) >>> 32;
            rv32m_muldiv_pkg::MULHU:  r = (ua * ub) >> 32;
            rv32m_muldiv_pkg::DIV:    r = (b == 0) ? -64'sd1 : (ovf ? sa : sa / sb);
            rv32m_muldiv_pkg::DIVU:   r = (b == 0) ? -64'sd1 : ua / ub;
            rv32m_muldiv_pkg::REM:    r = (b == 0) ? sa : (ovf ? 64'sd0 : sa % sb);
            default:                  r = (b == 0) ? ua : ua % ub;
        endcase
        return r[31:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // Present a request, hold it back while busy_o, then strobe start_i
    task automatic issue_op(input rv32m_muldiv_pkg::muldiv_op_e op,
                            input rv32m_muldiv_pkg::word_t a, input rv32m_muldiv_pkg::word_t b);
        int pending_mul;
        @(negedge clk_i);
        start_i     = 1'b0;
        op_i        = op;
        operand_a_i = a;
        operand_b_i = b;
        #1;
        while (busy_o) begin
            @(negedge clk_i);
            #1;
        end
        // A divide must not pass a multiply that is still in flight
        pending_mul = 0;
        foreach (lat_q[i]) begin
            if (lat_q[i] == MULT_LATENCY) begin
                pending_mul++;
            end
        end
        if (op[2] && (pending_mul != 0)) begin
            check_value("busy_o", 1, busy_o);
        end
        start_i = 1'b1;
        exp_q.push_back(ref_result(op, a, b));
        lat_q.push_back(op[2] ? int'(rv32m_muldiv_pkg::DIV_CYCLES) : MULT_LATENCY);
        issue_q.push_back(cycle);
        @(posedge clk_i);
    endtask

    task automatic wait_results();
        @(negedge clk_i);
        start_i = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
        end
    endtask

    task automatic report_test(input string name);
        $display("%-22s %s, %0d errors", name, (errors == err_start) ? "ok" : "FAIL",
                 errors - err_start);
        err_start = errors;
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk_i) begin
        if (rst_ni && done_o) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("done_o at %0t with no request in flight", $time);
            end else begin
                check_value("result_o", exp_q.pop_front(), result_o);
                check_value("done_o latency", lat_q.pop_front(), cycle - issue_q.pop_front());
            end
        end
    end

    // Budget per request covers the longest path
    initial begin
        repeat (16 + NUM_OPS * (rv32m_muldiv_pkg::DIV_CYCLES + MULT_LATENCY + 10)) begin
            @(posedge clk_i);
        end
        $display("Timeout, the DUT stopped returning results");
        $display("test failed");
        $finish;
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        rst_ni      = 1'b0;
        start_i     = 1'b0;
        op_i        = rv32m_muldiv_pkg::MUL;
        operand_a_i = '0;
        operand_b_i = '0;
        cycle       = 0;
        checks      = 0;
        errors      = 0;
        err_start   = 0;
        void'($urandom(4));

        // Outputs quiet during and just after reset
        repeat (16) begin
            @(negedge clk_i);
            check_value("done_o", 0, done_o);
            check_value("busy_o", 0, busy_o);
        end
        rst_ni = 1'b1;
        repeat (2) begin
            @(negedge clk_i);
            check_value("done_o", 0, done_o);
            check_value("busy_o", 0, busy_o);
            check_value("result_o", 0, result_o);
        end
        report_test("reset state");

        for (int o = 0; o < 4; o++) begin
            foreach (corners[i]) begin
                foreach (corners[j]) begin
                    issue_op(rv32m_muldiv_pkg::muldiv_op_e'(3'(o)), corners[i], corners[j]);
                    wait_results();
                end
            end
        end
        report_test("directed multiplies");

        // One multiply per cycle
        repeat (N_B2B) begin
            issue_op(rv32m_muldiv_pkg::muldiv_op_e'(3'($urandom_range(0, 3))),
                     $urandom(), $urandom());
        end
        wait_results();
        report_test("back-to-back multiplies");

        for (int o = 4; o < 8; o++) begin
            foreach (corners[i]) begin
                foreach (corners[j]) begin
                    issue_op(rv32m_muldiv_pkg::muldiv_op_e'(3'(o)), corners[i], corners[j]);
                    repeat (rv32m_muldiv_pkg::DIV_CYCLES) begin
                        @(negedge clk_i);
                        start_i = 1'b0;
                        check_value("busy_o", 1, busy_o);
                    end
                    wait_results();
                end
            end
        end
        report_test("directed divides");

        // Divide by zero and signed overflow
        for (int o = 4; o < 8; o++) begin
            issue_op(rv32m_muldiv_pkg::muldiv_op_e'(3'(o)), $urandom(), 32'h0);
            issue_op(rv32m_muldiv_pkg::muldiv_op_e'(3'(o)), 32'h0, 32'h0);
            issue_op(rv32m_muldiv_pkg::muldiv_op_e'(3'(o)), 32'h8000_0000, 32'hffff_ffff);
        end
        wait_results();
        report_test("special cases");

        // About one divisor in eight is zero
        repeat (N_RANDOM) begin
            issue_op(rv32m_muldiv_pkg::muldiv_op_e'(3'($urandom_range(0, 7))), $urandom(),
                     ($urandom_range(0, 7) == 0) ? 32'h0 : $urandom());
        end
        wait_results();
        report_test("random mixed stream");

        repeat (4) @(negedge clk_i);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d results never came back", exp_q.size());
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: rv32m_muldiv.f
verilog/rv32m_muldiv_pkg.sv
verilog/muldiv_if.sv
verilog/mult_unit.sv
verilog/div_unit.sv
verilog/muldiv_ctrl.sv
verilog/rv32m_muldiv_top.sv
bench/rv32m_muldiv_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module rv32m_muldiv_tb \
    -f rv32m_muldiv.f \
    -o sim_rv32m_muldiv

./obj_dir/sim_rv32m_muldiv | tee sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
